// File: common/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    localparam fwd_sel_t FWD_RF  = 2'd0;
    localparam fwd_sel_t FWD_EX  = 2'd1;
    localparam fwd_sel_t FWD_MEM = 2'd2;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;
    localparam word_t RESET_PC  = 32'h0000_0000;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     op_a;
        word_t     op_b;
        word_t     imm;
        reg_addr_t rd;
        reg_addr_t rs2;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      reg_we;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      is_load;
        logic      is_store;
        logic      reg_we;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     wb_data;
        reg_addr_t rd;
        logic      reg_we;
    } mem_wb_t;

endpackage

// File: logic/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              i_rst_n,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    input  rv_pkg::mem_wb_t   i_mem_wb,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);

    rv_pkg::word_t regs [32];
    logic          wr_en;

    assign wr_en = i_rst_n && i_mem_wb.valid && i_mem_wb.reg_we && (i_mem_wb.rd != '0);

    // x0 is cleared once and never written
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            regs[0] <= '0;
        end else if (wr_en) begin
            regs[i_mem_wb.rd] <= i_mem_wb.wb_data;
        end
    end

    // Same-cycle writeback is visible to decode
    assign o_rs1_data = (wr_en && i_mem_wb.rd == i_rs1) ? i_mem_wb.wb_data : regs[i_rs1];
    assign o_rs2_data = (wr_en && i_mem_wb.rd == i_rs2) ? i_mem_wb.wb_data : regs[i_rs2];

    a_x0_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_rs1 == '0 |-> o_rs1_data == '0) and (i_rs2 == '0 |-> o_rs2_data == '0))
        else $error("x0 read returned nonzero");

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    input  logic              i_uses_rs1,
    input  logic              i_uses_rs2,
    input  rv_pkg::id_ex_t    i_id_ex,
    input  rv_pkg::ex_mem_t   i_ex_mem,
    input  logic              i_taken,
    input  logic              i_imem_ack_n,
    input  logic              i_dmem_ack_n,
    output rv_pkg::fwd_sel_t  o_fwd_a,
    output rv_pkg::fwd_sel_t  o_fwd_b,
    output logic              o_stall,
    output logic              o_flush,
    output logic              o_freeze
);

    logic ex_wr;
    logic mem_wr;
    logic load_use;
    logic mem_access;

    // Loads in EX have no result yet, so they never forward
    assign ex_wr  = i_id_ex.valid && i_id_ex.reg_we && !i_id_ex.is_load && (i_id_ex.rd != '0);
    assign mem_wr = i_ex_mem.valid && i_ex_mem.reg_we && (i_ex_mem.rd != '0);

    assign o_fwd_a = (ex_wr && i_id_ex.rd == i_rs1)   ? rv_pkg::FWD_EX  :
                     (mem_wr && i_ex_mem.rd == i_rs1) ? rv_pkg::FWD_MEM : rv_pkg::FWD_RF;
    assign o_fwd_b = (ex_wr && i_id_ex.rd == i_rs2)   ? rv_pkg::FWD_EX  :
                     (mem_wr && i_ex_mem.rd == i_rs2) ? rv_pkg::FWD_MEM : rv_pkg::FWD_RF;

    assign load_use = i_id_ex.valid && i_id_ex.is_load && (i_id_ex.rd != '0) &&
                      ((i_uses_rs1 && i_id_ex.rd == i_rs1) ||
                       (i_uses_rs2 && i_id_ex.rd == i_rs2));

    // Flush wins over the load-use bubble
    assign o_stall = load_use && !i_taken;
    assign o_flush = i_taken;

    assign mem_access = i_ex_mem.valid && (i_ex_mem.is_load || i_ex_mem.is_store);
    assign o_freeze   = i_imem_ack_n || (mem_access && i_dmem_ack_n);

    always_comb begin
        // A taken transfer in EX cannot also be a load in EX
        if (!$isunknown({load_use, i_taken})) begin
            a_stall_flush: assert final (!(load_use && i_taken))
                else $error("load-use stall and flush from the same EX slot");
        end
        // Store data dependent on a load must have been split by the stall bubble
        if (!$isunknown({i_id_ex.valid, i_id_ex.is_store, i_ex_mem.valid, i_ex_mem.is_load})) begin
            a_store_after_load: assert final (!(i_id_ex.valid && i_id_ex.is_store &&
                i_ex_mem.valid && i_ex_mem.is_load && i_ex_mem.rd != '0 &&
                i_id_ex.rs2 == i_ex_mem.rd))
                else $error("store in EX reads a load still in MEM");
        end
    end

endmodule

// File: core/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_stall,
    input  logic            i_freeze,
    input  logic            i_flush,
    input  rv_pkg::word_t   i_target,
    input  rv_pkg::word_t   i_instr,
    output rv_pkg::word_t   o_pc,
    output rv_pkg::if_id_t  o_if_id
);

    rv_pkg::word_t pc_q;

    assign o_pc = pc_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc_q          <= rv_pkg::RESET_PC;
            o_if_id.valid <= 1'b0;
        end else if (!i_freeze) begin
            if (i_flush) begin
                // Wrong-path word is dropped
                pc_q          <= i_target;
                o_if_id.valid <= 1'b0;
                o_if_id.pc    <= pc_q;
                o_if_id.instr <= rv_pkg::NOP_INSTR;
            end else if (!i_stall) begin
                pc_q          <= pc_q + 32'd4;
                o_if_id.valid <= 1'b1;
                o_if_id.pc    <= pc_q;
                o_if_id.instr <= i_instr;
            end
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        pc_q[1:0] == 2'b00)
        else $error("fetch PC not word aligned");

endmodule

// File: core/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              i_rst_n,
    input  rv_pkg::if_id_t    i_if_id,
    input  rv_pkg::word_t     i_rf_a,
    input  rv_pkg::word_t     i_rf_b,
    input  rv_pkg::fwd_sel_t  i_fwd_a,
    input  rv_pkg::fwd_sel_t  i_fwd_b,
    input  rv_pkg::word_t     i_ex_fwd,
    input  rv_pkg::word_t     i_mem_fwd,
    input  logic              i_stall,
    input  logic              i_freeze,
    input  logic              i_flush,
    output rv_pkg::reg_addr_t o_rs1,
    output rv_pkg::reg_addr_t o_rs2,
    output logic              o_uses_rs1,
    output logic              o_uses_rs2,
    output rv_pkg::id_ex_t    o_id_ex
);

    rv_pkg::word_t   instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;
    rv_pkg::alu_op_t alu_op;
    rv_pkg::id_ex_t  id_ex_d;

    function automatic rv_pkg::word_t fwd_mux(rv_pkg::fwd_sel_t sel, rv_pkg::word_t rf,
                                              rv_pkg::word_t ex, rv_pkg::word_t mem);
        case (sel)
            rv_pkg::FWD_EX:  return ex;
            rv_pkg::FWD_MEM: return mem;
            default:         return rf;
        endcase
    endfunction

    assign instr  = i_if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign o_rs1  = instr[19:15];
    assign o_rs2  = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign o_uses_rs1 = i_if_id.valid && (opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM,
                        rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH});
    assign o_uses_rs2 = i_if_id.valid &&
                        (opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH});

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == rv_pkg::OPC_OP && funct7[5]) ? rv_pkg::ALU_SUB
                                                                       : rv_pkg::ALU_ADD;
            3'b001:  alu_op = rv_pkg::ALU_SLL;
            3'b010:  alu_op = rv_pkg::ALU_SLT;
            3'b011:  alu_op = rv_pkg::ALU_SLTU;
            3'b100:  alu_op = rv_pkg::ALU_XOR;
            3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_op = rv_pkg::ALU_OR;
            default: alu_op = rv_pkg::ALU_AND;
        endcase
        // Address math for memory ops
        if (opcode == rv_pkg::OPC_LUI) begin
            alu_op = rv_pkg::ALU_PASS_B;
        end else if (opcode != rv_pkg::OPC_OP && opcode != rv_pkg::OPC_OP_IMM) begin
            alu_op = rv_pkg::ALU_ADD;
        end
    end

    always_comb begin
        id_ex_d        = '0;
        id_ex_d.valid  = i_if_id.valid && !i_stall && !i_flush;
        id_ex_d.pc     = i_if_id.pc;
        id_ex_d.op_a   = fwd_mux(i_fwd_a, i_rf_a, i_ex_fwd, i_mem_fwd);
        id_ex_d.op_b   = fwd_mux(i_fwd_b, i_rf_b, i_ex_fwd, i_mem_fwd);
        id_ex_d.rd     = instr[11:7];
        id_ex_d.rs2    = o_rs2;
        id_ex_d.alu_op = alu_op;
        case (opcode)
            rv_pkg::OPC_OP: begin
                id_ex_d.reg_we = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                id_ex_d.imm     = imm_i;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.reg_we  = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                id_ex_d.imm     = imm_u;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.reg_we  = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                id_ex_d.imm     = imm_i;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.is_load = 1'b1;
                id_ex_d.reg_we  = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                id_ex_d.imm      = imm_s;
                id_ex_d.use_imm  = 1'b1;
                id_ex_d.is_store = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                id_ex_d.imm       = imm_b;
                id_ex_d.is_branch = 1'b1;
                id_ex_d.branch_ne = funct3[0];
            end
            rv_pkg::OPC_JAL: begin
                id_ex_d.imm    = imm_j;
                id_ex_d.is_jal = 1'b1;
                id_ex_d.reg_we = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_id_ex.valid <= 1'b0;
        end else if (!i_freeze) begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

// File: core/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_freeze,
    input  rv_pkg::id_ex_t  i_id_ex,
    output rv_pkg::word_t   o_ex_fwd,
    output logic            o_taken,
    output rv_pkg::word_t   o_target,
    output rv_pkg::ex_mem_t o_ex_mem
);

    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t alu_y;
    logic [4:0]    shamt;
    logic          equal;

    assign a     = i_id_ex.op_a;
    assign b     = i_id_ex.use_imm ? i_id_ex.imm : i_id_ex.op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (i_id_ex.alu_op)
            rv_pkg::ALU_SUB:    alu_y = a - b;
            rv_pkg::ALU_SLL:    alu_y = a << shamt;
            rv_pkg::ALU_SLT:    alu_y = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:   alu_y = {31'b0, a < b};
            rv_pkg::ALU_XOR:    alu_y = a ^ b;
            rv_pkg::ALU_SRL:    alu_y = a >> shamt;
            rv_pkg::ALU_SRA:    alu_y = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:     alu_y = a | b;
            rv_pkg::ALU_AND:    alu_y = a & b;
            rv_pkg::ALU_PASS_B: alu_y = b;
            default:            alu_y = a + b;
        endcase
    end

    // JAL links PC+4
    assign o_ex_fwd = i_id_ex.is_jal ? i_id_ex.pc + 32'd4 : alu_y;

    assign equal    = (i_id_ex.op_a == i_id_ex.op_b);
    assign o_taken  = i_id_ex.valid &&
                      (i_id_ex.is_jal || (i_id_ex.is_branch && (equal != i_id_ex.branch_ne)));
    assign o_target = i_id_ex.pc + i_id_ex.imm;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_ex_mem.valid <= 1'b0;
        end else if (!i_freeze) begin
            o_ex_mem.valid      <= i_id_ex.valid;
            o_ex_mem.result     <= o_ex_fwd;
            o_ex_mem.store_data <= i_id_ex.op_b;
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.is_load    <= i_id_ex.is_load;
            o_ex_mem.is_store   <= i_id_ex.is_store;
            o_ex_mem.reg_we     <= i_id_ex.reg_we;
        end
    end

endmodule

// File: core/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_freeze,
    input  rv_pkg::ex_mem_t i_ex_mem,
    input  rv_pkg::word_t   i_dmem_rdata,
    output logic            o_dmem_req,
    output logic            o_dmem_we,
    output rv_pkg::word_t   o_dmem_addr,
    output rv_pkg::word_t   o_dmem_wdata,
    output rv_pkg::word_t   o_mem_fwd,
    output rv_pkg::mem_wb_t o_mem_wb
);

    assign o_dmem_req   = i_ex_mem.valid && (i_ex_mem.is_load || i_ex_mem.is_store);
    assign o_dmem_we    = i_ex_mem.valid && i_ex_mem.is_store;
    assign o_dmem_addr  = i_ex_mem.result;
    assign o_dmem_wdata = i_ex_mem.store_data;

    // Writeback value, also the MEM forward
    assign o_mem_fwd = i_ex_mem.is_load ? i_dmem_rdata : i_ex_mem.result;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mem_wb.valid <= 1'b0;
        end else if (!i_freeze) begin
            o_mem_wb.valid   <= i_ex_mem.valid;
            o_mem_wb.wb_data <= o_mem_fwd;
            o_mem_wb.rd      <= i_ex_mem.rd;
            o_mem_wb.reg_we  <= i_ex_mem.reg_we;
        end
    end

    a_we_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_dmem_we |-> o_dmem_req)
        else $error("data write without request");

    // A waiting access must not change under the memory
    a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_dmem_req && i_freeze |=> $stable({o_dmem_we, o_dmem_addr, o_dmem_wdata}))
        else $error("data request changed while frozen");

endmodule

// File: core/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          i_rst_n,
    output rv_pkg::word_t o_imem_addr,
    input  rv_pkg::word_t i_imem_data,
    input  logic          i_imem_ack_n,
    output logic          o_dmem_req,
    output logic          o_dmem_we,
    output rv_pkg::word_t o_dmem_addr,
    output rv_pkg::word_t o_dmem_wdata,
    input  rv_pkg::word_t i_dmem_rdata,
    input  logic          i_dmem_ack_n
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::mem_wb_t   mem_wb;

    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    logic              uses_rs1;
    logic              uses_rs2;
    rv_pkg::word_t     rf_a;
    rv_pkg::word_t     rf_b;
    rv_pkg::fwd_sel_t  fwd_a;
    rv_pkg::fwd_sel_t  fwd_b;
    rv_pkg::word_t     ex_fwd;
    rv_pkg::word_t     mem_fwd;
    rv_pkg::word_t     target;
    logic              taken;
    logic              stall;
    logic              flush;
    logic              freeze;

    fetch_stage fetch_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_stall  (stall),
        .i_freeze (freeze),
        .i_flush  (flush),
        .i_target (target),
        .i_instr  (i_imem_data),
        .o_pc     (o_imem_addr),
        .o_if_id  (if_id)
    );

    decode_stage decode_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_if_id    (if_id),
        .i_rf_a     (rf_a),
        .i_rf_b     (rf_b),
        .i_fwd_a    (fwd_a),
        .i_fwd_b    (fwd_b),
        .i_ex_fwd   (ex_fwd),
        .i_mem_fwd  (mem_fwd),
        .i_stall    (stall),
        .i_freeze   (freeze),
        .i_flush    (flush),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_uses_rs1 (uses_rs1),
        .o_uses_rs2 (uses_rs2),
        .o_id_ex    (id_ex)
    );

    execute_stage execute_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_freeze (freeze),
        .i_id_ex  (id_ex),
        .o_ex_fwd (ex_fwd),
        .o_taken  (taken),
        .o_target (target),
        .o_ex_mem (ex_mem)
    );

    mem_stage mem_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_freeze     (freeze),
        .i_ex_mem     (ex_mem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_req   (o_dmem_req),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_mem_fwd    (mem_fwd),
        .o_mem_wb     (mem_wb)
    );

    regfile regfile_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_mem_wb   (mem_wb),
        .o_rs1_data (rf_a),
        .o_rs2_data (rf_b)
    );

    hazard_unit hazard_i (
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .i_uses_rs1   (uses_rs1),
        .i_uses_rs2   (uses_rs2),
        .i_id_ex      (id_ex),
        .i_ex_mem     (ex_mem),
        .i_taken      (taken),
        .i_imem_ack_n (i_imem_ack_n),
        .i_dmem_ack_n (i_dmem_ack_n),
        .o_fwd_a      (fwd_a),
        .o_fwd_b      (fwd_b),
        .o_stall      (stall),
        .o_flush      (flush),
        .o_freeze     (freeze)
    );

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic          clk,
    input  rv_pkg::word_t i_imem_addr,
    output rv_pkg::word_t o_imem_data,
    output logic          o_imem_ack_n,
    input  logic          i_dmem_req,
    input  logic          i_dmem_we,
    input  rv_pkg::word_t i_dmem_addr,
    input  rv_pkg::word_t i_dmem_wdata,
    output rv_pkg::word_t o_dmem_rdata,
    output logic          o_dmem_ack_n
);

    rv_pkg::word_t rom [64];
    rv_pkg::word_t ram [256];
    integer        seed;
    rv_pkg::word_t rnd;

    initial begin
        seed         = 32'h3bbadf37;
        o_imem_ack_n = 1'b1;
        o_dmem_ack_n = 1'b1;
    end

    // Both memories answer in the same cycle
    assign o_imem_data  = rom[i_imem_addr[7:2]];
    assign o_dmem_rdata = ram[i_dmem_addr[9:2]];

    always @(posedge clk) begin
        if (i_dmem_req && i_dmem_we && !o_dmem_ack_n) begin
            ram[i_dmem_addr[9:2]] <= i_dmem_wdata;
        end
    end

    // Each port is not ready in about one cycle out of four
    always @(posedge clk) begin
        #1;
        rnd          = $random(seed);
        o_imem_ack_n = (rnd[1:0] == 2'b00);
        o_dmem_ack_n = (rnd[9:8] == 2'b00);
    end

    task automatic clear_memories();
        for (int i = 0; i < 64; i++) begin
            rom[i] = rv_pkg::NOP_INSTR;
        end
        // Every word carries its own index
        for (int i = 0; i < 256; i++) begin
            ram[i] = {16'(i), ~16'(i)};
        end
    endtask

    task automatic load_instr(int idx, rv_pkg::word_t instr);
        rom[idx] = instr;
    endtask

    task automatic write_word(rv_pkg::word_t addr, rv_pkg::word_t data);
        ram[addr[9:2]] = data;
    endtask

endmodule

// File: tests/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    logic          clk;
    logic          rst_n;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_data;
    logic          imem_ack_n;
    logic          dmem_req;
    logic          dmem_we;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    rv_pkg::word_t dmem_rdata;
    logic          dmem_ack_n;

    logic          store_fire;
    logic          in_table;
    logic [3:0]    slot;
    rv_pkg::word_t exp_data [16];
    string         exp_name [16];
    rv_pkg::word_t load_word;
    logic [15:0]   stored;
    logic          done;
    logic          fetched;
    int            prog_len;
    int            cycles;

    rv_core dut_i (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_data  (imem_data),
        .i_imem_ack_n (imem_ack_n),
        .o_dmem_req   (dmem_req),
        .o_dmem_we    (dmem_we),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .i_dmem_ack_n (dmem_ack_n)
    );

    tb_mem_model mem_i (
        .clk          (clk),
        .i_imem_addr  (imem_addr),
        .o_imem_data  (imem_data),
        .o_imem_ack_n (imem_ack_n),
        .i_dmem_req   (dmem_req),
        .i_dmem_we    (dmem_we),
        .i_dmem_addr  (dmem_addr),
        .i_dmem_wdata (dmem_wdata),
        .o_dmem_rdata (dmem_rdata),
        .o_dmem_ack_n (dmem_ack_n)
    );

    always #50 clk = ~clk;

    // Results land at 0x100 + 4 * slot
    assign store_fire = dmem_req && dmem_we && !dmem_ack_n;
    assign slot       = dmem_addr[5:2];
    assign in_table   = (dmem_addr[31:6] == 26'h4) && (dmem_addr[1:0] == 2'b00) && (slot < 4'd10);

    function automatic rv_pkg::word_t r_type(logic [2:0] f3, logic [6:0] f7,
                                             rv_pkg::reg_addr_t rd, rv_pkg::reg_addr_t rs1,
                                             rv_pkg::reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::word_t i_type(logic [6:0] opc, logic [2:0] f3,
                                             rv_pkg::reg_addr_t rd, rv_pkg::reg_addr_t rs1,
                                             logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::word_t s_type(rv_pkg::reg_addr_t rs2, rv_pkg::reg_addr_t rs1,
                                             logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::word_t b_type(logic [2:0] f3, rv_pkg::reg_addr_t rs1,
                                             rv_pkg::reg_addr_t rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t u_type(rv_pkg::reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, rv_pkg::OPC_LUI};
    endfunction

    function automatic rv_pkg::word_t j_type(rv_pkg::reg_addr_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    task automatic emit(rv_pkg::word_t instr);
        mem_i.load_instr(prog_len, instr);
        prog_len++;
    endtask

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic load_program();
        // Dependent ALU chain, forwards from EX and MEM
        emit(i_type(rv_pkg::OPC_OP_IMM, 3'b000, 1, 0, 12'd5));
        emit(i_type(rv_pkg::OPC_OP_IMM, 3'b000, 2, 1, 12'd7));
        emit(r_type(3'b000, 7'h00, 3, 1, 2));
        emit(u_type(4, 20'h12345));
        emit(r_type(3'b000, 7'h20, 5, 4, 3));
        emit(r_type(3'b100, 7'h00, 6, 5, 2));
        emit(r_type(3'b010, 7'h00, 7, 3, 5));
        emit(r_type(3'b111, 7'h00, 8, 6, 4));
        emit(r_type(3'b110, 7'h00, 9, 8, 1));
        emit(i_type(rv_pkg::OPC_OP_IMM, 3'b100, 11, 9, 12'hfff));
        emit(i_type(rv_pkg::OPC_OP_IMM, 3'b111, 12, 11, 12'h0f0));
        emit(i_type(rv_pkg::OPC_OP_IMM, 3'b010, 13, 11, 12'h000));
        emit(i_type(rv_pkg::OPC_OP_IMM, 3'b000, 10, 0, 12'h100));
        emit(s_type(3, 10, 12'd0));
        emit(s_type(5, 10, 12'd4));
        emit(s_type(6, 10, 12'd8));
        emit(s_type(7, 10, 12'd12));
        emit(s_type(9, 10, 12'd16));
        emit(s_type(12, 10, 12'd20));
        emit(s_type(13, 10, 12'd24));
        // lw x15 from 0x200, used at once
        emit(i_type(rv_pkg::OPC_LOAD, 3'b010, 15, 10, 12'h100));
        emit(r_type(3'b000, 7'h00, 16, 15, 1));
        emit(s_type(16, 10, 12'd28));
        // Taken transfers each skip a store to 0x3f0
        emit(i_type(rv_pkg::OPC_OP_IMM, 3'b000, 20, 0, 12'h3f0));
        emit(b_type(3'b000, 20, 20, 13'd8));
        emit(s_type(0, 20, 12'd0));
        emit(b_type(3'b001, 1, 2, 13'd8));
        emit(s_type(0, 20, 12'd0));
        emit(b_type(3'b000, 1, 2, 13'd8));
        emit(s_type(2, 10, 12'd32));
        emit(j_type(21, 21'd8));
        emit(s_type(0, 20, 12'd0));
        emit(s_type(21, 10, 12'd36));
        // Done marker at 0x3f4, then spin
        emit(s_type(1, 20, 12'd4));
        emit(j_type(0, 21'd0));
    endtask

    task automatic fill_expected();
        rv_pkg::word_t x [32];
        x[1]  = 32'd5;
        x[2]  = x[1] + 32'd7;
        x[3]  = x[1] + x[2];
        x[4]  = 32'h12345 << 12;
        x[5]  = x[4] - x[3];
        x[6]  = x[5] ^ x[2];
        x[7]  = ($signed(x[3]) < $signed(x[5])) ? 32'd1 : 32'd0;
        x[8]  = x[6] & x[4];
        x[9]  = x[8] | x[1];
        x[11] = x[9] ^ 32'hffff_ffff;
        x[12] = x[11] & 32'h0000_00f0;
        x[13] = ($signed(x[11]) < 0) ? 32'd1 : 32'd0;
        exp_data[0] = x[3];
        exp_data[1] = x[5];
        exp_data[2] = x[6];
        exp_data[3] = x[7];
        exp_data[4] = x[9];
        exp_data[5] = x[12];
        exp_data[6] = x[13];
        exp_data[7] = load_word + x[1];
        exp_data[8] = x[2];
        // Link of the jal at 0x78
        exp_data[9] = 32'h78 + 32'd4;
        for (int i = 0; i < 16; i++) begin
            exp_name[i] = (i < 5) ? "alu_forward" : "imm_ops";
        end
        exp_name[7] = "load_use";
        exp_name[8] = "branch_not_taken";
        exp_name[9] = "jal_link";
    endtask

    always @(posedge clk) begin
        if (rst_n && !imem_ack_n) begin
            fetched <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (rst_n && store_fire) begin
            if (in_table) begin
                stored[slot] = 1'b1;
            end
            if (dmem_addr == 32'h3f4) begin
                done = 1'b1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        !fetched |-> (imem_addr == rv_pkg::RESET_PC && !dmem_req && !dmem_we))
        else stop_with_failure("core left its reset state before the first fetch");

    a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire && in_table |-> dmem_wdata == exp_data[slot])
        else stop_with_failure($sformatf("MISMATCH test %s expected %h actual %h",
            exp_name[$sampled(slot)], exp_data[$sampled(slot)], $sampled(dmem_wdata)));

    a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> dmem_addr != 32'h3f0)
        else stop_with_failure("a skipped store after a taken branch or jump reached memory");

    a_known_addr: assert property (@(posedge clk) disable iff (!rst_n)
        store_fire |-> (in_table || dmem_addr inside {32'h3f0, 32'h3f4}))
        else stop_with_failure($sformatf("store to unexpected address %h",
            $sampled(dmem_addr)));

    // Pending access and fetch address hold while the core waits
    a_dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && (dmem_ack_n || imem_ack_n) |=> $stable({dmem_we, dmem_addr, dmem_wdata}))
        else stop_with_failure("data request changed while memory was not ready");

    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        imem_ack_n |=> $stable(imem_addr))
        else stop_with_failure("fetch address changed while instruction memory was not ready");

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        prog_len  = 0;
        cycles    = 0;
        done      = 1'b0;
        fetched   = 1'b0;
        stored    = '0;
        load_word = 32'h2468_ace1;
        fill_expected();
        mem_i.clear_memories();
        mem_i.write_word(32'h200, load_word);
        load_program();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!done && cycles < 40 * prog_len) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            stop_with_failure($sformatf("timeout: no store to the done address in %0d cycles",
                cycles));
        end else if (stored[9:0] != '1) begin
            stop_with_failure("program finished but some result stores never happened");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: sim.f
common/rv_pkg.sv
logic/regfile.sv
logic/hazard_unit.sv
core/fetch_stage.sv
core/decode_stage.sv
core/execute_stage.sv
core/mem_stage.sv
core/rv_core.sv
tests/tb_mem_model.sv
tests/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - common/rv_pkg.sv
      - logic/regfile.sv
      - logic/hazard_unit.sv
      - core/fetch_stage.sv
      - core/decode_stage.sv
      - core/execute_stage.sv
      - core/mem_stage.sv
      - core/rv_core.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_rv_core.sv
